//--- build.f
+incdir+src
src/lq_ptr_pkg.sv
src/lq_mem_pkg.sv
src/lq_store_if.sv
src/lq_entry_if.sv
src/lq_pointers.sv
src/lq_entries.sv
src/lq_violation_check.sv
src/load_queue.sv
testbench/tb_load_queue.sv

//--- src/load_queue.sv
`include "lq_defines.svh"

module load_queue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dis_en_i,
    input  lq_mem_pkg::rob_idx_t        dis_rob_idx_i,
    input  logic                        issue_en_i,
    input  lq_ptr_pkg::lq_idx_t         issue_idx_i,
    input  lq_mem_pkg::paddr_t          issue_addr_i,
    input  lq_mem_pkg::byte_mask_t      issue_mask_i,
    input  logic                        issue_miss_i,
    input  logic                        refill_en_i,
    input  lq_ptr_pkg::lq_idx_t         refill_idx_i,
    input  lq_mem_pkg::lq_data_t        refill_data_i,
    input  logic [`LQ_COMMIT_NUM_W-1:0] commit_num_i,
    input  logic                        store_en_i,
    input  lq_mem_pkg::paddr_t          store_addr_i,
    input  lq_mem_pkg::byte_mask_t      store_mask_i,
    input  lq_ptr_pkg::lq_ptr_t         store_ptr_i,
    input  logic                        wb_ready_i,
    output lq_ptr_pkg::lq_ptr_t         dis_ptr_o,
    output logic                        full_o,
    output logic                        vio_valid_o,
    output lq_ptr_pkg::lq_idx_t         vio_idx_o,
    output lq_mem_pkg::rob_idx_t        vio_rob_idx_o,
    output logic                        wb_valid_o,
    output lq_mem_pkg::rob_idx_t        wb_rob_idx_o,
    output lq_mem_pkg::lq_data_t        wb_data_o
);
    logic dis_fire;

    lq_store_if st_if ();
    lq_entry_if ent_if ();

    // no allocation while full
    assign dis_fire = dis_en_i & ~full_o;

    assign st_if.en    = store_en_i;
    assign st_if.waddr = store_addr_i[`LQ_PADDR_W-1:`LQ_OFFSET_W];
    assign st_if.mask  = store_mask_i;
    assign st_if.ptr   = store_ptr_i;

    lq_pointers u_pointers (
        .clk          (clk),
        .rst          (rst),
        .dis_en_i     (dis_fire),
        .commit_num_i (commit_num_i),
        .dis_ptr_o    (dis_ptr_o),
        .full_o       (full_o),
        .ent_if       (ent_if.ptrs)
    );

    lq_entries u_entries (
        .clk             (clk),
        .rst             (rst),
        .alloc_en_i      (dis_fire),
        .alloc_idx_i     (dis_ptr_o[`LQ_IDX_W-1:0]),
        .alloc_rob_idx_i (dis_rob_idx_i),
        .issue_en_i      (issue_en_i),
        .issue_idx_i     (issue_idx_i),
        .issue_addr_i    (issue_addr_i),
        .issue_mask_i    (issue_mask_i),
        .issue_miss_i    (issue_miss_i),
        .refill_en_i     (refill_en_i),
        .refill_idx_i    (refill_idx_i),
        .refill_data_i   (refill_data_i),
        .commit_num_i    (commit_num_i),
        .wb_ready_i      (wb_ready_i),
        .wb_valid_o      (wb_valid_o),
        .wb_rob_idx_o    (wb_rob_idx_o),
        .wb_data_o       (wb_data_o),
        .ent_if          (ent_if.entries)
    );

    lq_violation_check u_vio_check (
        .clk           (clk),
        .rst           (rst),
        .st_if         (st_if.chk),
        .ent_if        (ent_if.chk),
        .vio_valid_o   (vio_valid_o),
        .vio_idx_o     (vio_idx_o),
        .vio_rob_idx_o (vio_rob_idx_o)
    );

endmodule

//--- src/lq_defines.svh
`ifndef LQ_DEFINES_SVH
`define LQ_DEFINES_SVH

// queue geometry
`define LQ_DEPTH        16
`define LQ_IDX_W        4

// commit port
`define LQ_COMMIT_W     2
`define LQ_COMMIT_NUM_W 2

// memory side widths
`define LQ_PADDR_W      32
`define LQ_WORD_BYTES   8
`define LQ_OFFSET_W     3
`define LQ_XLEN         64

// rob side
`define LQ_ROB_W        6

`endif

//--- src/lq_entries.sv
`include "lq_defines.svh"

module lq_entries (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc_en_i,
    input  lq_ptr_pkg::lq_idx_t         alloc_idx_i,
    input  lq_mem_pkg::rob_idx_t        alloc_rob_idx_i,
    input  logic                        issue_en_i,
    input  lq_ptr_pkg::lq_idx_t         issue_idx_i,
    input  lq_mem_pkg::paddr_t          issue_addr_i,
    input  lq_mem_pkg::byte_mask_t      issue_mask_i,
    input  logic                        issue_miss_i,
    input  logic                        refill_en_i,
    input  lq_ptr_pkg::lq_idx_t         refill_idx_i,
    input  lq_mem_pkg::lq_data_t        refill_data_i,
    input  logic [`LQ_COMMIT_NUM_W-1:0] commit_num_i,
    input  logic                        wb_ready_i,
    output logic                        wb_valid_o,
    output lq_mem_pkg::rob_idx_t        wb_rob_idx_o,
    output lq_mem_pkg::lq_data_t        wb_data_o,
    lq_entry_if.entries                 ent_if
);
    import lq_ptr_pkg::*;
    import lq_mem_pkg::*;

    logic [`LQ_DEPTH-1:0] valid_q;
    logic [`LQ_DEPTH-1:0] addr_valid_q;
    logic [`LQ_DEPTH-1:0] miss_q;
    logic [`LQ_DEPTH-1:0] data_valid_q;
    logic [`LQ_DEPTH-1:0] wb_done_q;

    word_addr_t waddr_q [`LQ_DEPTH];
    byte_mask_t mask_q  [`LQ_DEPTH];
    rob_idx_t   rob_q   [`LQ_DEPTH];
    lq_data_t   data_q  [`LQ_DEPTH];

    logic [`LQ_DEPTH-1:0] commit_clr;
    logic [`LQ_DEPTH-1:0] in_flight;
    logic [`LQ_DEPTH-1:0] pend;
    lq_idx_t              pick_idx;

    // writeback pipe: select stage, then output register
    logic     sel_valid_q;
    lq_idx_t  sel_idx_q;
    logic     out_valid_q;
    lq_idx_t  out_idx_q;
    rob_idx_t out_rob_q;
    lq_data_t out_data_q;
    logic     wb_stall;
    logic     wb_xfer;

    // up to two slots freed from the head
    always_comb begin
        lq_idx_t slot;
        commit_clr = '0;
        for (int j = 0; j < `LQ_COMMIT_W; j++) begin
            slot = ent_if.head[`LQ_IDX_W-1:0] + lq_idx_t'(j);
            if (j < int'(commit_num_i)) begin
                commit_clr[slot] = 1'b1;
            end
        end
    end

    // keep entries already in the pipe out of the select
    always_comb begin
        in_flight = '0;
        if (sel_valid_q) begin
            in_flight[sel_idx_q] = 1'b1;
        end
        if (out_valid_q) begin
            in_flight[out_idx_q] = 1'b1;
        end
    end

    assign pend = valid_q & miss_q & data_valid_q & ~wb_done_q & ~in_flight;

    // lowest pending index
    always_comb begin
        pick_idx = '0;
        for (int i = `LQ_DEPTH-1; i >= 0; i--) begin
            if (pend[i]) begin
                pick_idx = lq_idx_t'(i);
            end
        end
    end

    assign wb_stall = out_valid_q & ~wb_ready_i;
    assign wb_xfer  = out_valid_q & wb_ready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q      <= '0;
            addr_valid_q <= '0;
            miss_q       <= '0;
            data_valid_q <= '0;
            wb_done_q    <= '0;
            sel_valid_q  <= 1'b0;
            sel_idx_q    <= '0;
            out_valid_q  <= 1'b0;
            out_idx_q    <= '0;
        end else begin
            valid_q <= valid_q & ~commit_clr;
            if (alloc_en_i) begin
                valid_q[alloc_idx_i]      <= 1'b1;
                addr_valid_q[alloc_idx_i] <= 1'b0;
                miss_q[alloc_idx_i]       <= 1'b0;
                data_valid_q[alloc_idx_i] <= 1'b0;
                wb_done_q[alloc_idx_i]    <= 1'b0;
            end
            if (issue_en_i) begin
                addr_valid_q[issue_idx_i] <= 1'b1;
                miss_q[issue_idx_i]       <= issue_miss_i;
            end
            if (refill_en_i && miss_q[refill_idx_i]) begin
                data_valid_q[refill_idx_i] <= 1'b1;
            end
            if (wb_xfer) begin
                wb_done_q[out_idx_q] <= 1'b1;
            end
            if (!wb_stall) begin
                sel_valid_q <= |pend;
                sel_idx_q   <= pick_idx;
                out_valid_q <= sel_valid_q;
                out_idx_q   <= sel_idx_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en_i) begin
            rob_q[alloc_idx_i] <= alloc_rob_idx_i;
        end
        if (issue_en_i) begin
            waddr_q[issue_idx_i] <= issue_addr_i[`LQ_PADDR_W-1:`LQ_OFFSET_W];
            mask_q[issue_idx_i]  <= issue_mask_i;
        end
        if (refill_en_i && miss_q[refill_idx_i]) begin
            data_q[refill_idx_i] <= refill_data_i;
        end
        if (!wb_stall) begin
            out_rob_q  <= rob_q[sel_idx_q];
            out_data_q <= data_q[sel_idx_q];
        end
    end

    assign wb_valid_o   = out_valid_q;
    assign wb_rob_idx_o = out_rob_q;
    assign wb_data_o    = out_data_q;

    assign ent_if.valid      = valid_q;
    assign ent_if.addr_valid = addr_valid_q;
    assign ent_if.waddr      = waddr_q;
    assign ent_if.mask       = mask_q;
    assign ent_if.rob_idx    = rob_q;

endmodule

//--- src/lq_entry_if.sv
`include "lq_defines.svh"

interface lq_entry_if;
    import lq_ptr_pkg::*;
    import lq_mem_pkg::*;

    logic [`LQ_DEPTH-1:0] valid;
    logic [`LQ_DEPTH-1:0] addr_valid;
    word_addr_t           waddr   [`LQ_DEPTH];
    byte_mask_t           mask    [`LQ_DEPTH];
    rob_idx_t             rob_idx [`LQ_DEPTH];
    lq_ptr_t              head;
    lq_ptr_t              tail;

    modport entries (
        output valid, addr_valid, waddr, mask, rob_idx,
        input  head
    );
    modport ptrs (output head, tail);
    modport chk (
        input valid, addr_valid, waddr, mask, rob_idx, tail
    );

endinterface

//--- src/lq_mem_pkg.sv
`include "lq_defines.svh"

package lq_mem_pkg;

    typedef logic [`LQ_PADDR_W-1:0] paddr_t;

    // address of a whole data word, byte offset stripped
    typedef logic [`LQ_PADDR_W-`LQ_OFFSET_W-1:0] word_addr_t;

    typedef logic [`LQ_WORD_BYTES-1:0] byte_mask_t;

    typedef logic [`LQ_XLEN-1:0] lq_data_t;

    typedef logic [`LQ_ROB_W-1:0] rob_idx_t;

endpackage

//--- src/lq_pointers.sv
`include "lq_defines.svh"

module lq_pointers (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        dis_en_i,
    input  logic [`LQ_COMMIT_NUM_W-1:0] commit_num_i,
    output lq_ptr_pkg::lq_ptr_t         dis_ptr_o,
    output logic                        full_o,
    lq_entry_if.ptrs                    ent_if
);
    import lq_ptr_pkg::*;

    lq_ptr_t   head_q;
    lq_ptr_t   tail_q;
    lq_ptr_t   head_n;
    lq_ptr_t   tail_n;
    lq_count_t count_q;
    lq_count_t count_n;
    logic      full_q;

    // depth is a power of two, so the carry out of the index
    // lands in the direction bit and flips it on wrap
    assign head_n = head_q + lq_ptr_t'(commit_num_i);
    assign tail_n = tail_q + lq_ptr_t'(dis_en_i);

    assign count_n = count_q + lq_count_t'(dis_en_i) - lq_count_t'(commit_num_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            full_q  <= 1'b0;
        end else begin
            head_q  <= head_n;
            tail_q  <= tail_n;
            count_q <= count_n;
            full_q  <= (count_n == lq_count_t'(`LQ_DEPTH));
        end
    end

    // next dispatch goes to the current tail
    assign dis_ptr_o = tail_q;
    assign full_o    = full_q;

    assign ent_if.head = head_q;
    assign ent_if.tail = tail_q;

endmodule

//--- src/lq_ptr_pkg.sv
`include "lq_defines.svh"

package lq_ptr_pkg;

    // slot inside the queue
    typedef logic [`LQ_IDX_W-1:0] lq_idx_t;

    // msb is the direction bit, flips every time the index wraps
    typedef logic [`LQ_IDX_W:0] lq_ptr_t;

    // 0 up to LQ_DEPTH inclusive
    typedef logic [`LQ_IDX_W:0] lq_count_t;

endpackage

//--- src/lq_store_if.sv
interface lq_store_if;
    import lq_ptr_pkg::*;
    import lq_mem_pkg::*;

    logic       en;
    word_addr_t waddr;
    byte_mask_t mask;
    // tail seen by the store at dispatch, first younger load
    lq_ptr_t    ptr;

    modport src (
        output en, waddr, mask, ptr
    );

    modport chk (
        input en, waddr, mask, ptr
    );

endinterface

//--- src/lq_violation_check.sv
`include "lq_defines.svh"

module lq_violation_check (
    input  logic                 clk,
    input  logic                 rst,
    lq_store_if.chk              st_if,
    lq_entry_if.chk              ent_if,
    output logic                 vio_valid_o,
    output lq_ptr_pkg::lq_idx_t  vio_idx_o,
    output lq_mem_pkg::rob_idx_t vio_rob_idx_o
);
    import lq_ptr_pkg::*;
    import lq_mem_pkg::*;

    lq_ptr_t              span;
    logic [`LQ_DEPTH-1:0] hit_vec;

    // stage 1 regs
    logic [`LQ_DEPTH-1:0] s1_vec_q;
    lq_idx_t              s1_base_q;

    lq_idx_t              oldest_idx;

    // stage 2 regs
    logic                 vio_valid_q;
    lq_idx_t              vio_idx_q;
    rob_idx_t             vio_rob_q;

    // loads from the store pointer up to the tail are younger;
    // a span of 16 or more covers every slot
    assign span = ent_if.tail - st_if.ptr;

    always_comb begin
        lq_idx_t offset;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            offset = lq_idx_t'(i) - st_if.ptr[`LQ_IDX_W-1:0];
            hit_vec[i] = st_if.en
                       & ent_if.valid[i]
                       & ent_if.addr_valid[i]
                       & (ent_if.waddr[i] == st_if.waddr)
                       & (|(ent_if.mask[i] & st_if.mask))
                       & (lq_ptr_t'(offset) < span);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_vec_q <= '0;
        end else begin
            s1_vec_q <= hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        s1_base_q <= st_if.ptr[`LQ_IDX_W-1:0];
    end

    // oldest younger load is the hit nearest the store pointer
    always_comb begin
        lq_idx_t cand;
        oldest_idx = s1_base_q;
        for (int k = `LQ_DEPTH-1; k >= 0; k--) begin
            cand = s1_base_q + lq_idx_t'(k);
            if (s1_vec_q[cand]) begin
                oldest_idx = cand;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vio_valid_q <= 1'b0;
        end else begin
            vio_valid_q <= |s1_vec_q;
        end
    end

    always_ff @(posedge clk) begin
        vio_idx_q <= oldest_idx;
        vio_rob_q <= ent_if.rob_idx[oldest_idx];
    end

    assign vio_valid_o   = vio_valid_q;
    assign vio_idx_o     = vio_idx_q;
    assign vio_rob_idx_o = vio_rob_q;

endmodule

//--- testbench/tb_load_queue.sv
`include "lq_defines.svh"

module tb_load_queue;
    timeunit 1ns;
    timeprecision 100ps;

    import lq_ptr_pkg::*;
    import lq_mem_pkg::*;

    logic       clk;
    logic       rst;
    logic       dis_en_i, issue_en_i, issue_miss_i, refill_en_i, store_en_i, wb_ready_i;
    rob_idx_t   dis_rob_idx_i;
    lq_idx_t    issue_idx_i, refill_idx_i;
    paddr_t     issue_addr_i, store_addr_i;
    byte_mask_t issue_mask_i, store_mask_i;
    lq_data_t   refill_data_i;
    logic [`LQ_COMMIT_NUM_W-1:0] commit_num_i;
    lq_ptr_t    store_ptr_i;
    lq_ptr_t    dis_ptr_o;
    logic       full_o, vio_valid_o, wb_valid_o;
    lq_idx_t    vio_idx_o;
    rob_idx_t   vio_rob_idx_o, wb_rob_idx_o;
    lq_data_t   wb_data_o;

    // model of the queue
    logic       m_valid [`LQ_DEPTH];
    logic       m_av    [`LQ_DEPTH];
    logic       m_miss  [`LQ_DEPTH];
    word_addr_t m_waddr [`LQ_DEPTH];
    byte_mask_t m_mask  [`LQ_DEPTH];
    rob_idx_t   m_rob   [`LQ_DEPTH];
    lq_ptr_t    m_head, m_tail;
    int         m_count;

    // outstanding refilled loads still owed on writeback
    logic       wb_check;
    rob_idx_t   wb_rob_q[$];
    lq_data_t   wb_data_q[$];
    logic       held_valid, held_ready;
    rob_idx_t   held_rob;
    lq_data_t   held_data;

    // expected vio result per cycle slot
    logic       exp_v   [4];
    lq_idx_t    exp_idx [4];
    rob_idx_t   exp_rob [4];
    logic [1:0] cyc = '0;

    load_queue dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 2'd1;

    task automatic check_eq(input logic [63:0] act, input logic [63:0] exp,
                            input string what);
        if (act !== exp) begin
            $display("ERROR %0t ns: %s, got %0h, expected %0h", $time, what, act, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    // younger loads sit from the store pointer up to the tail and the first hit is the oldest
    function automatic logic ref_violation(input word_addr_t waddr, input byte_mask_t mask,
                                           input lq_ptr_t sptr, output lq_idx_t idx,
                                           output rob_idx_t rob);
        lq_ptr_t window;
        lq_idx_t slot;
        window = m_tail - sptr;
        idx = '0;
        rob = '0;
        for (int off = 0; off < `LQ_DEPTH; off++) begin
            slot = sptr[`LQ_IDX_W-1:0] + lq_idx_t'(off);
            if (off < int'(window) && m_valid[slot] && m_av[slot] &&
                m_waddr[slot] == waddr && (m_mask[slot] & mask) != '0) begin
                idx = slot;
                rob = m_rob[slot];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    always @(negedge clk) begin
        logic [1:0] s;
        s = cyc - 2'd2;
        if (!rst) begin
            check_eq(vio_valid_o, exp_v[s], "vio_valid_o");
            if (exp_v[s]) begin
                check_eq(vio_idx_o, exp_idx[s], "vio_idx_o");
                check_eq(vio_rob_idx_o, exp_rob[s], "vio_rob_idx_o");
            end
        end
    end

    task automatic idle();
        dis_en_i     = 1'b0;
        issue_en_i   = 1'b0;
        refill_en_i  = 1'b0;
        commit_num_i = '0;
        store_en_i   = 1'b0;
        wb_ready_i   = 1'(($urandom_range(0, 2) != 0));
    endtask

    // checks this cycle's outputs and moves the model past the next edge
    task automatic step();
        logic     fire;
        logic     hit;
        lq_idx_t  slot;
        lq_idx_t  vi;
        rob_idx_t vr;
        int       k;
        check_eq(dis_ptr_o, m_tail, "dis_ptr_o");
        check_eq(full_o, m_count == `LQ_DEPTH, "full_o");
        if (held_valid && !held_ready) begin
            check_eq(wb_valid_o, 1'b1, "wb_valid_o under back-pressure");
            check_eq(wb_rob_idx_o, held_rob, "wb_rob_idx_o under back-pressure");
            check_eq(wb_data_o, held_data, "wb_data_o under back-pressure");
        end
        if (wb_valid_o && wb_ready_i && wb_check) begin
            k = -1;
            for (int n = 0; n < wb_rob_q.size(); n++) begin
                if (k < 0 && wb_rob_q[n] == wb_rob_idx_o && wb_data_q[n] == wb_data_o) begin
                    k = n;
                end
            end
            if (k < 0) begin
                abort_run("writeback of a load that was never refilled or was already sent");
            end else begin
                wb_rob_q.delete(k);
                wb_data_q.delete(k);
            end
        end
        held_valid = wb_valid_o;
        held_ready = wb_ready_i;
        held_rob   = wb_rob_idx_o;
        held_data  = wb_data_o;
        hit = ref_violation(store_addr_i[`LQ_PADDR_W-1:`LQ_OFFSET_W], store_mask_i,
                            store_ptr_i, vi, vr);
        exp_v[cyc]   = hit && store_en_i;
        exp_idx[cyc] = vi;
        exp_rob[cyc] = vr;
        fire = dis_en_i && m_count < `LQ_DEPTH;
        if (refill_en_i && m_miss[refill_idx_i] && wb_check) begin
            wb_rob_q.push_back(m_rob[refill_idx_i]);
            wb_data_q.push_back(refill_data_i);
        end
        if (issue_en_i) begin
            m_av[issue_idx_i]    = 1'b1;
            m_miss[issue_idx_i]  = issue_miss_i;
            m_waddr[issue_idx_i] = issue_addr_i[`LQ_PADDR_W-1:`LQ_OFFSET_W];
            m_mask[issue_idx_i]  = issue_mask_i;
        end
        for (int j = 0; j < int'(commit_num_i); j++) begin
            slot = m_head[`LQ_IDX_W-1:0] + lq_idx_t'(j);
            m_valid[slot] = 1'b0;
        end
        if (fire) begin
            slot          = m_tail[`LQ_IDX_W-1:0];
            m_valid[slot] = 1'b1;
            m_av[slot]    = 1'b0;
            m_miss[slot]  = 1'b0;
            m_rob[slot]   = dis_rob_idx_i;
        end
        m_head  = m_head + lq_ptr_t'(commit_num_i);
        m_tail  = m_tail + lq_ptr_t'(fire);
        m_count = m_count + int'(fire) - int'(commit_num_i);
        @(negedge clk);
    endtask

    task automatic dispatch(input rob_idx_t rob);
        idle();
        dis_en_i      = 1'b1;
        dis_rob_idx_i = rob;
        step();
    endtask

    task automatic commit(input int n);
        idle();
        commit_num_i = n;
        step();
    endtask

    task automatic issue(input int idx, input paddr_t addr, input byte_mask_t mask,
                         input logic miss);
        idle();
        issue_en_i   = 1'b1;
        issue_idx_i  = lq_idx_t'(idx);
        issue_addr_i = addr;
        issue_mask_i = mask;
        issue_miss_i = miss;
        step();
    endtask

    // hand-worked result is checked before the store goes to the DUT
    task automatic store_check(input paddr_t addr, input byte_mask_t mask, input lq_ptr_t sptr,
                               input logic hit, input lq_idx_t idx);
        logic     r;
        lq_idx_t  ri;
        rob_idx_t rr;
        r = ref_violation(addr[`LQ_PADDR_W-1:`LQ_OFFSET_W], mask, sptr, ri, rr);
        check_eq(r, hit, "reference violation flag");
        if (hit) begin
            check_eq(ri, idx, "reference oldest index");
        end
        idle();
        store_en_i   = 1'b1;
        store_addr_i = addr;
        store_mask_i = mask;
        store_ptr_i  = sptr;
        step();
    endtask

    initial begin
        void'($urandom(32'h3982));
        rst = 1'b1;
        idle();
        wb_ready_i    = 1'b0;
        dis_rob_idx_i = '0;
        issue_idx_i   = '0;
        issue_addr_i  = '0;
        issue_mask_i  = '0;
        issue_miss_i  = 1'b0;
        refill_idx_i  = '0;
        refill_data_i = '0;
        store_addr_i  = '0;
        store_mask_i  = '0;
        store_ptr_i   = '0;
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
            m_av[i]    = 1'b0;
            m_miss[i]  = 1'b0;
        end
        foreach (exp_v[i]) exp_v[i] = 1'b0;
        m_head     = '0;
        m_tail     = '0;
        m_count    = 0;
        wb_check   = 1'b1;
        held_valid = 1'b0;
        held_ready = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // fill up and then try one refused dispatch
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            check_eq(dis_ptr_o, i, "dispatch pointer while filling");
            dispatch(rob_idx_t'(i + 20));
        end
        check_eq(full_o, 1'b1, "full_o after 16 dispatches");
        dispatch(6'd63);
        check_eq(dis_ptr_o, 5'd16, "dis_ptr_o after refused dispatch");

        commit(2);
        commit(1);
        commit(2);
        check_eq(full_o, 1'b0, "full_o after commits");
        for (int i = 0; i < 3; i++) begin
            check_eq(dis_ptr_o, 16 + i, "wrapped dispatch pointer");
            dispatch(rob_idx_t'(40 + i));
        end

        // entries 6 and 9 hit while the rest miss and get refilled
        for (int i = 5; i <= 10; i++) issue(i, 32'h1000 + i * 8, 8'hFF, i != 6 && i != 9);
        for (int i = 5; i <= 10; i++) begin
            idle();
            refill_en_i   = 1'b1;
            refill_idx_i  = lq_idx_t'(i);
            refill_data_i = {$urandom, $urandom};
            step();
        end
        for (int t = 0; t < 200 && wb_rob_q.size() > 0; t++) begin
            idle();
            step();
        end
        if (wb_rob_q.size() != 0) begin
            abort_run("timed out waiting for refilled loads to be written back");
        end
        idle();
        repeat (8) step();

        issue(11, 32'h2000, 8'h0F, 1'b0);
        issue(12, 32'h2004, 8'hF0, 1'b0);
        issue(13, 32'h2000, 8'h03, 1'b0);
        issue(14, 32'h2000, 8'h01, 1'b0);
        store_check(32'h2002, 8'h0F, 5'd12, 1'b1, 4'd13);
        store_check(32'h2000, 8'h30, 5'd12, 1'b1, 4'd12);
        store_check(32'h2000, 8'h0F, 5'd15, 1'b0, 4'd0);
        store_check(32'h2000, 8'h40, 5'd13, 1'b0, 4'd0);

        wb_check = 1'b0;
        for (int c = 0; c < 2000; c++) begin
            idle();
            dis_en_i      = 1'($urandom_range(0, 1));
            dis_rob_idx_i = rob_idx_t'($urandom);
            issue_idx_i   = lq_idx_t'($urandom);
            issue_en_i    = m_valid[issue_idx_i] && ($urandom_range(0, 1) != 0);
            issue_addr_i  = $urandom & 32'h1F;
            issue_mask_i  = byte_mask_t'($urandom);
            issue_miss_i  = 1'($urandom_range(0, 1));
            refill_idx_i  = lq_idx_t'($urandom);
            refill_en_i   = m_valid[refill_idx_i] && m_miss[refill_idx_i];
            refill_data_i = {$urandom, $urandom};
            commit_num_i  = $urandom_range(0, m_count < 2 ? m_count : 2);
            store_en_i    = 1'($urandom_range(0, 1));
            store_addr_i  = $urandom & 32'h1F;
            store_mask_i  = byte_mask_t'($urandom);
            store_ptr_i   = m_head + lq_ptr_t'($urandom_range(0, m_count));
            step();
        end
        idle();
        repeat (3) step();
        $display("Test passed");
        $finish;
    end

endmodule
